/* verilog/dmem_consts.svh */
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// ------------------------------
// Data path widths
// ------------------------------

// Core data word
`define DMEM_DATA_W 32

// Core byte address
`define DMEM_ADDR_W 32

// One byte lane of the word
`define DMEM_BYTE_W 8

// ------------------------------
// Memory bus and store queue
// ------------------------------

// Bus is word addressed, so two fewer bits than the byte address
`define DMEM_WADDR_W 30

// One enable per byte lane, big endian
`define DMEM_BE_W 4

// Store queue depth is a power of two
`define DMEM_SQ_BITS 3
`define DMEM_SQ_DEPTH (1 << `DMEM_SQ_BITS)

`endif

/* verilog/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

`include "dmem_consts.svh"

   // ------------------------------
   // Vector types
   // ------------------------------

   typedef logic [`DMEM_DATA_W-1:0]  word_t;
   typedef logic [`DMEM_ADDR_W-1:0]  byte_addr_t;
   typedef logic [`DMEM_WADDR_W-1:0] word_addr_t;

   // Bit 3 is byte 0, the most significant byte
   typedef logic [`DMEM_BE_W-1:0]    byteena_t;

   // Bit 3 of the encoding marks a store
   typedef enum logic [3:0] {
      LB  = 4'h0,
      LBU = 4'h4,
      LH  = 4'h1,
      LHU = 4'h5,
      LW  = 4'h3,
      SB  = 4'h8,
      SH  = 4'h9,
      SW  = 4'hb
   } mem_op_t;

   // Request sequencing
   typedef enum logic [2:0] {
      IDLE,
      STORE_PUSH,
      LOAD_DRAIN,
      LOAD_ISSUE,
      LOAD_WAIT,
      ACK_HOLD
   } access_state_t;

   // ------------------------------
   // Bundles
   // ------------------------------

   // Core request, held stable while req is high
   typedef struct packed {
      mem_op_t    op;
      byte_addr_t addr;
      word_t      wdata;
   } core_req_t;

   // One pending memory write, already lane aligned
   typedef struct packed {
      word_addr_t waddr;
      word_t      data;
      byteena_t   be;
   } sq_entry_t;

   // Memory bus command
   typedef struct packed {
      word_addr_t address;
      logic       read;
      logic       write;
      word_t      writedata;
      byteena_t   byteena;
   } dmem_cmd_t;

endpackage

`default_nettype wire

/* verilog/store_align.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmem_consts.svh"

module store_align import dmem_pkg::*; (
   input  core_req_t core_req,
   output sq_entry_t entry
);

   // Extra rotation per size, added to the low address bits
   logic [1:0] rot_delta;
   logic [1:0] rot;
   word_t      wd;
   word_t      lane_data;
   byteena_t   be;

   always_comb begin
      case (core_req.op)
         SB:      rot_delta = 2'd1;
         SH:      rot_delta = 2'd2;
         default: rot_delta = 2'd0;
      endcase
   end

   // Wraps in two bits
   assign rot = core_req.addr[1:0] + rot_delta;
   assign wd  = core_req.wdata;

   // Rotate right by whole bytes
   // so the low byte or half lands in its big-endian lane
   always_comb begin
      case (rot)
         2'd1:    lane_data = {wd[`DMEM_BYTE_W-1:0], wd[`DMEM_DATA_W-1:`DMEM_BYTE_W]};
         2'd2:    lane_data = {wd[2*`DMEM_BYTE_W-1:0], wd[`DMEM_DATA_W-1:2*`DMEM_BYTE_W]};
         2'd3:    lane_data = {wd[3*`DMEM_BYTE_W-1:0], wd[`DMEM_DATA_W-1:3*`DMEM_BYTE_W]};
         default: lane_data = wd;
      endcase
   end

   // Byte enables, lane 0 on the top bit
   always_comb begin
      case (core_req.op)
         SW:      be = 4'hf;
         SH:      be = core_req.addr[1] ? 4'h3 : 4'hc;
         SB:      be = 4'h8 >> core_req.addr[1:0];
         // Loads never reach the queue
         default: be = 4'h0;
      endcase
   end

   // Drop the byte offset for the word address
   assign entry.waddr = core_req.addr[`DMEM_ADDR_W-1:2];
   assign entry.data  = lane_data;
   assign entry.be    = be;

endmodule

`default_nettype wire

/* verilog/store_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmem_consts.svh"

module store_queue import dmem_pkg::*; (
   input  logic      clock,
   input  logic      rst_n,
   input  logic      push,
   input  sq_entry_t entry_in,
   input  logic      pop,
   output sq_entry_t head,
   output logic      empty,
   output logic      full
);

   // ------------------------------
   // Storage and pointers
   // ------------------------------

   sq_entry_t mem [0:`DMEM_SQ_DEPTH-1];

   logic [`DMEM_SQ_BITS-1:0] wr_ptr;
   logic [`DMEM_SQ_BITS-1:0] rd_ptr;
   logic [`DMEM_SQ_BITS-1:0] wr_ptr_inc;
   logic [`DMEM_SQ_BITS-1:0] rd_ptr_inc;
   logic                     do_push;
   logic                     do_pop;

   // Pointers wrap naturally at the depth
   assign wr_ptr_inc = wr_ptr + 1'b1;
   assign rd_ptr_inc = rd_ptr + 1'b1;

   // One slot stays unused
   // so full and empty can be told apart
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr_inc == rd_ptr);

   // Ignore requests the queue cannot serve
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // ------------------------------
   // Write side
   // ------------------------------

   always_ff @(posedge clock) begin
      if (do_push) begin
         mem[wr_ptr] <= entry_in;
      end
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr_inc;
         end
         // Pop side advances independently
         if (do_pop) begin
            rd_ptr <= rd_ptr_inc;
         end
      end
   end

   // ------------------------------
   // Read side
   // ------------------------------

   // Oldest entry, valid whenever not empty
   assign head = mem[rd_ptr];

endmodule

`default_nettype wire

/* verilog/load_extract.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmem_consts.svh"

module load_extract import dmem_pkg::*; (
   input  logic       clock,
   input  logic       rst_n,
   input  logic       capture,
   input  mem_op_t    op,
   input  logic [1:0] byte_sel,
   input  word_t      readdata,
   output word_t      rdata
);

   localparam int EXT_B = `DMEM_DATA_W - `DMEM_BYTE_W;
   localparam int EXT_H = `DMEM_DATA_W - 2*`DMEM_BYTE_W;

   word_t                     byte_up;
   word_t                     half_up;
   logic [`DMEM_BYTE_W-1:0]   sel_byte;
   logic [2*`DMEM_BYTE_W-1:0] sel_half;
   word_t                     ext;

   // Shift the addressed part to the top
   // byte 0 already sits there
   assign byte_up = readdata << {byte_sel, 3'b000};
   assign half_up = readdata << {byte_sel[1], 4'b0000};

   assign sel_byte = byte_up[`DMEM_DATA_W-1 -: `DMEM_BYTE_W];
   assign sel_half = half_up[`DMEM_DATA_W-1 -: 2*`DMEM_BYTE_W];

   // ------------------------------
   // Extension by op
   // ------------------------------

   always_comb begin
      case (op)
         LB:      ext = {{EXT_B{sel_byte[`DMEM_BYTE_W-1]}}, sel_byte};
         LBU:     ext = {{EXT_B{1'b0}}, sel_byte};
         LH:      ext = {{EXT_H{sel_half[2*`DMEM_BYTE_W-1]}}, sel_half};
         LHU:     ext = {{EXT_H{1'b0}}, sel_half};
         // LW and anything else pass the word
         default: ext = readdata;
      endcase
   end

   // Result register, loaded on the readdatavalid cycle
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         rdata <= '0;
      end else if (capture) begin
         rdata <= ext;
      end
   end

endmodule

`default_nettype wire

/* verilog/dmem_access_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_access_fsm import dmem_pkg::*; (
   input  logic       clock,
   input  logic       rst_n,
   input  logic       req,
   input  mem_op_t    op,
   input  word_addr_t waddr,
   output logic       ack,
   output logic       push,
   output logic       pop,
   input  sq_entry_t  head,
   input  logic       empty,
   input  logic       full,
   input  logic       waitrequest,
   input  logic       readdatavalid,
   output logic       capture,
   output dmem_cmd_t  dmem_cmd
);

   access_state_t state;
   access_state_t state_next;

   logic is_store;
   logic write_done;
   logic issue;

   assign is_store = (op == SB) || (op == SH) || (op == SW);

   // No write left on the bus once this edge passes
   assign write_done = !dmem_cmd.write || !waitrequest;

   // ------------------------------
   // Queue and bus strobes
   // ------------------------------

   // Push waits for a free slot
   assign push = (state == STORE_PUSH) && !full;

   // Drain whenever the bus takes a new command
   assign pop = !waitrequest && !empty;

   // Read only goes out when drain has nothing to send
   assign issue = (state == LOAD_ISSUE) && !waitrequest && !pop;

   // Read data sampled in the cycle it is valid
   assign capture = (state == LOAD_WAIT) && readdatavalid;

   // Held until the core drops req
   assign ack = (state == ACK_HOLD);

   // ------------------------------
   // Next state
   // ------------------------------

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (req) begin
               state_next = is_store ? STORE_PUSH : LOAD_DRAIN;
            end
         end
         STORE_PUSH: begin
            if (!full) begin
               state_next = ACK_HOLD;
            end
         end
         // Loads see every older store in memory
         LOAD_DRAIN: begin
            if (empty && write_done) begin
               state_next = LOAD_ISSUE;
            end
         end
         LOAD_ISSUE: begin
            if (issue) begin
               state_next = LOAD_WAIT;
            end
         end
         LOAD_WAIT: begin
            if (readdatavalid) begin
               state_next = ACK_HOLD;
            end
         end
         ACK_HOLD: begin
            if (!req) begin
               state_next = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   // ------------------------------
   // Bus command register
   // ------------------------------

   // Frozen while waitrequest is high
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         dmem_cmd <= '0;
      end else if (!waitrequest) begin
         // Previous command taken on this edge
         dmem_cmd.read  <= 1'b0;
         dmem_cmd.write <= 1'b0;
         if (pop) begin
            dmem_cmd.address   <= head.waddr;
            dmem_cmd.write     <= 1'b1;
            dmem_cmd.writedata <= head.data;
            dmem_cmd.byteena   <= head.be;
         end else if (issue) begin
            dmem_cmd.address <= waddr;
            dmem_cmd.read    <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/dmem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_stage import dmem_pkg::*; (
   input  logic      clock,
   input  logic      rst_n,
   input  logic      req,
   input  core_req_t core_req,
   output logic      ack,
   output word_t     rdata,
   output dmem_cmd_t dmem_cmd,
   input  logic      waitrequest,
   input  logic      readdatavalid,
   input  word_t     readdata
);

   sq_entry_t aligned_entry;
   sq_entry_t sq_head;
   logic      sq_push;
   logic      sq_pop;
   logic      sq_empty;
   logic      sq_full;
   logic      load_capture;

   // ------------------------------
   // Store path
   // ------------------------------

   store_align store_align_i (
      .core_req (core_req),
      .entry    (aligned_entry)
   );

   store_queue store_queue_i (
      .clock    (clock),
      .rst_n    (rst_n),
      .push     (sq_push),
      .entry_in (aligned_entry),
      .pop      (sq_pop),
      .head     (sq_head),
      .empty    (sq_empty),
      .full     (sq_full)
   );

   // ------------------------------
   // Load path and control
   // ------------------------------

   // Byte offset comes straight from the held request
   load_extract load_extract_i (
      .clock    (clock),
      .rst_n    (rst_n),
      .capture  (load_capture),
      .op       (core_req.op),
      .byte_sel (core_req.addr[1:0]),
      .readdata (readdata),
      .rdata    (rdata)
   );

   dmem_access_fsm dmem_access_fsm_i (
      .clock         (clock),
      .rst_n         (rst_n),
      .req           (req),
      .op            (core_req.op),
      .waddr         (aligned_entry.waddr),
      .ack           (ack),
      .push          (sq_push),
      .pop           (sq_pop),
      .head          (sq_head),
      .empty         (sq_empty),
      .full          (sq_full),
      .waitrequest   (waitrequest),
      .readdatavalid (readdatavalid),
      .capture       (load_capture),
      .dmem_cmd      (dmem_cmd)
   );

endmodule

`default_nettype wire

/* tests/dmem_stage_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmem_consts.svh"

module dmem_stage_assertions import dmem_pkg::*; (
   input logic      clock,
   input logic      rst_n,
   input logic      req,
   input logic      ack,
   input logic      waitrequest,
   input logic      sq_push,
   input logic      sq_pop,
   input logic      sq_full,
   input dmem_cmd_t dmem_cmd
);

   // Queue occupancy rebuilt from the push and pop strobes
   logic [`DMEM_SQ_BITS:0] sq_count;

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         sq_count <= '0;
      end else begin
         case ({sq_push, sq_pop})
            2'b10:   sq_count <= sq_count + 1'b1;
            2'b01:   sq_count <= sq_count - 1'b1;
            default: sq_count <= sq_count;
         endcase
      end
   end

   // A pending command holds while memory stalls
   cmd_stable: assert property (@(posedge clock) disable iff (!rst_n)
      (dmem_cmd.read || dmem_cmd.write) && waitrequest |=> $stable(dmem_cmd))
      else $error("bus command changed while waitrequest was high");

   rw_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
      !(dmem_cmd.read && dmem_cmd.write))
      else $error("read and write set in the same bus command");

   // Four-phase rule lets ack drop only after req
   ack_hold: assert property (@(posedge clock) disable iff (!rst_n)
      ack && req |=> ack)
      else $error("ack fell while req was still high");

   // Seven entries fill the queue because one slot stays free
   push_room: assert property (@(posedge clock) disable iff (!rst_n)
      sq_push |-> sq_count < `DMEM_SQ_DEPTH - 1)
      else $error("store queue pushed with no free slot");

   full_flag: assert property (@(posedge clock) disable iff (!rst_n)
      sq_full == (sq_count == `DMEM_SQ_DEPTH - 1))
      else $error("store queue full flag disagrees with its occupancy");

endmodule

bind dmem_stage dmem_stage_assertions dmem_stage_assertions_i (
   .clock       (clock),
   .rst_n       (rst_n),
   .req         (req),
   .ack         (ack),
   .waitrequest (waitrequest),
   .sq_push     (sq_push),
   .sq_pop      (sq_pop),
   .sq_full     (sq_full),
   .dmem_cmd    (dmem_cmd)
);

`default_nettype wire

/* tests/tb_dmem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dmem_stage import dmem_pkg::*; ();

   localparam int          MAX_PAT    = 64;
   localparam int          WAIT_LIMIT = 2000;
   localparam logic [31:0] END_MARK   = 32'hff;

   logic      clock;
   logic      rst_n;
   logic      req;
   core_req_t core_req;
   logic      ack;
   word_t     rdata;
   dmem_cmd_t dmem_cmd;
   logic      waitrequest;
   logic      readdatavalid;
   word_t     readdata;

   // Five columns per pattern line
   logic [31:0] pat [0:5*MAX_PAT-1];
   int          errors;
   int          timeouts;
   logic        heavy_bp;
   logic [15:0] lfsr;

   // Memory model with at most one read in flight
   word_t      mem [0:63];
   int         rd_left;
   word_t      rd_word;

   // Word address of the load now in progress
   word_addr_t exp_rd_waddr;
   logic       rd_expected;

   // Writes still owed to the bus with the oldest first
   word_addr_t exp_waddr [$];
   byteena_t   exp_be [$];
   word_t      exp_data [$];

   dmem_stage dmem_stage_i (
      .clock         (clock),
      .rst_n         (rst_n),
      .req           (req),
      .core_req      (core_req),
      .ack           (ack),
      .rdata         (rdata),
      .dmem_cmd      (dmem_cmd),
      .waitrequest   (waitrequest),
      .readdatavalid (readdatavalid),
      .readdata      (readdata)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // ------------------------------
   // Helpers
   // ------------------------------

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic rand_bit();
      logic fb;
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] rand_bits(int n);
      logic [7:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[6:0], rand_bit()};
      end
      return v;
   endfunction

   // Every byte depends on the whole word index
   function automatic word_t fill_word(int idx);
      return {8'(idx), 8'(~idx), 8'(idx * 7), 8'(idx ^ 'ha0)};
   endfunction

   // Lane 0 is the top byte
   function automatic word_t lane_mask(byteena_t be);
      return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   endfunction

   task automatic check_word(string name, word_t got, word_t exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_waddr(string name, word_addr_t got, word_addr_t exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_be(string name, byteena_t got, byteena_t exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // Expected bus write for a store with zeros outside the enabled lanes
   task automatic expect_store(core_req_t r);
      byteena_t be;
      word_t    data;
      case (r.op)
         SW: begin
            be   = 4'b1111;
            data = r.wdata;
         end
         SH: begin
            be   = r.addr[1] ? 4'b0011 : 4'b1100;
            data = r.addr[1] ? {16'h0000, r.wdata[15:0]} : {r.wdata[15:0], 16'h0000};
         end
         default: begin
            be   = 4'b1000 >> r.addr[1:0];
            data = {r.wdata[7:0], 24'h000000} >> {r.addr[1:0], 3'b000};
         end
      endcase
      exp_waddr.push_back(r.addr[31:2]);
      exp_be.push_back(be);
      exp_data.push_back(data);
   endtask

   // ------------------------------
   // Memory model
   // ------------------------------

   always @(posedge clock) begin
      word_t mask;
      readdatavalid <= 1'b0;
      // Countdown to the data beat
      if (rd_left > 0) begin
         rd_left = rd_left - 1;
         if (rd_left == 0) begin
            readdatavalid <= 1'b1;
            readdata      <= rd_word;
         end
      end
      // Write taken on this edge
      if (!waitrequest && dmem_cmd.write) begin
         if (exp_waddr.size() == 0) begin
            errors++;
            $display("Bus write to word %h arrived with no store waiting for it",
                     dmem_cmd.address);
         end else begin
            check_waddr("dmem_cmd.address", dmem_cmd.address, exp_waddr.pop_front());
            check_be("dmem_cmd.byteena", dmem_cmd.byteena, exp_be[0]);
            check_word("dmem_cmd.writedata", dmem_cmd.writedata & lane_mask(exp_be[0]),
                       exp_data.pop_front());
            void'(exp_be.pop_front());
         end
         mask = lane_mask(dmem_cmd.byteena);
         mem[dmem_cmd.address[5:0]] = (mem[dmem_cmd.address[5:0]] & ~mask) |
                                      (dmem_cmd.writedata & mask);
      end
      // Data follows a taken read 1 to 3 cycles later
      if (!waitrequest && dmem_cmd.read) begin
         if (!rd_expected) begin
            errors++;
            $display("Bus read from word %h arrived with no load waiting for it",
                     dmem_cmd.address);
         end else begin
            check_waddr("dmem_cmd.address", dmem_cmd.address, exp_rd_waddr);
         end
         rd_expected = 1'b0;
         rd_word = mem[dmem_cmd.address[5:0]];
         rd_left = 1 + int'(rand_bits(2) % 8'd3);
      end
      // Heavy mode lets about one cycle in 32 through
      if (heavy_bp) begin
         waitrequest <= (rand_bits(5) != 8'h00);
      end else begin
         waitrequest <= (rand_bits(2) == 8'h03);
      end
   end

   // ------------------------------
   // Core side driver
   // ------------------------------

   task automatic run_request(core_req_t r, word_t expected);
      int n;
      @(posedge clock);
      req      <= 1'b1;
      core_req <= r;
      if (r.op inside {SB, SH, SW}) begin
         expect_store(r);
      end else begin
         exp_rd_waddr = r.addr[31:2];
         rd_expected  = 1'b1;
      end
      n = 0;
      @(posedge clock);
      while (!ack && n < WAIT_LIMIT) begin
         @(posedge clock);
         n++;
      end
      if (!ack) begin
         timeouts++;
         $display("Timed out waiting for ack on request to address %h", r.addr);
         return;
      end
      // Load data is registered before ack rises
      if (!(r.op inside {SB, SH, SW})) begin
         if (rd_expected) begin
            errors++;
            $display("Load to address %h acknowledged before its bus read", r.addr);
         end
         check_word("rdata", rdata, expected);
      end
      req <= 1'b0;
      n = 0;
      @(posedge clock);
      while (ack && n < WAIT_LIMIT) begin
         @(posedge clock);
         n++;
      end
      if (ack) begin
         timeouts++;
         $display("Timed out waiting for ack to drop after address %h", r.addr);
      end
   endtask

   initial begin
      int        n_pat;
      core_req_t r;
      errors        = 0;
      timeouts      = 0;
      lfsr          = 16'd3;
      rst_n         = 1'b0;
      req           = 1'b0;
      core_req      = '0;
      waitrequest   = 1'b0;
      readdatavalid = 1'b0;
      readdata      = '0;
      heavy_bp      = 1'b0;
      rd_left       = 0;
      rd_word       = '0;
      exp_rd_waddr  = '0;
      rd_expected   = 1'b0;
      for (int i = 0; i < 64; i++) begin
         mem[i] = fill_word(i);
      end
      $readmemh("tests/dmem_patterns.txt", pat);
      repeat (5) @(posedge clock);
      rst_n <= 1'b1;
      // Bus and ack stay quiet until the first request
      for (int c = 0; c < 8; c++) begin
         @(posedge clock);
         if (ack || dmem_cmd.read || dmem_cmd.write) begin
            errors++;
            $display("Ack or bus command active before the first request at %0t", $time);
         end
      end
      n_pat = 0;
      while (n_pat < MAX_PAT && pat[5*n_pat] != END_MARK && timeouts == 0) begin
         r.op     = mem_op_t'(pat[5*n_pat][3:0]);
         r.addr   = pat[5*n_pat+1];
         r.wdata  = pat[5*n_pat+2];
         heavy_bp <= pat[5*n_pat+4][0];
         run_request(r, pat[5*n_pat+3]);
         n_pat++;
      end
      if (timeouts == 0 && exp_waddr.size() != 0) begin
         errors++;
         $display("%0d store writes never reached the bus", exp_waddr.size());
      end
      $display("errors %0d, timeouts %0d, patterns run %0d", errors, timeouts, n_pat);
      if (errors == 0 && timeouts == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/dmem_patterns.txt */
// Columns: op, byte address, write data, expected load result, heavy waitrequest
// Op codes: 0 LB, 4 LBU, 1 LH, 5 LHU, 3 LW, 8 SB, 9 SH, b SW; op ff ends the list
b 00000010 11223344 00000000 0
8 00000011 deadbeaa 00000000 0
9 00000012 1234beef 00000000 0
3 00000010 00000000 11aabeef 0
0 00000011 00000000 ffffffaa 0
4 00000011 00000000 000000aa 0
1 00000012 00000000 ffffbeef 0
5 00000012 00000000 0000beef 0
0 00000010 00000000 00000011 0
1 00000010 00000000 000011aa 0
8 00000020 000000f0 00000000 0
8 00000021 ffffff81 00000000 0
8 00000022 00000072 00000000 0
8 00000023 12345663 00000000 0
3 00000020 00000000 f0817263 0
0 00000020 00000000 fffffff0 0
4 00000023 00000000 00000063 0
0 00000021 00000000 ffffff81 0
0 00000022 00000000 00000072 0
9 00000024 aaaa8001 00000000 0
9 00000026 00007ffe 00000000 0
1 00000024 00000000 ffff8001 0
1 00000026 00000000 00007ffe 0
5 00000024 00000000 00008001 0
3 00000024 00000000 80017ffe 0
b 00000040 c0de0010 00000000 1
b 00000044 c0de0011 00000000 1
b 00000048 c0de0012 00000000 1
b 0000004c c0de0013 00000000 1
b 00000050 c0de0014 00000000 1
b 00000054 c0de0015 00000000 1
b 00000058 c0de0016 00000000 1
b 0000005c c0de0017 00000000 1
b 00000060 c0de0018 00000000 1
b 00000064 c0de0019 00000000 1
3 00000064 00000000 c0de0019 1
9 00000042 0000f00d 00000000 0
5 00000042 00000000 0000f00d 0
3 00000040 00000000 c0def00d 0
3 00000050 00000000 c0de0014 0
ff 00000000 00000000 00000000 0

/* list.f */
+incdir+verilog
verilog/dmem_pkg.sv
verilog/store_align.sv
verilog/store_queue.sv
verilog/load_extract.sv
verilog/dmem_access_fsm.sv
verilog/dmem_stage.sv
tests/dmem_stage_assertions.sv
tests/tb_dmem_stage.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and scan the output for the pass line
verilator --binary --assert -Wno-fatal -j 0 --top-module tb_dmem_stage -f list.f \
   && ./obj_dir/Vtb_dmem_stage | tee /dev/stderr | grep -F '** PASS **' > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
